/* rtefi_pkg.sv */
// Shared constants for the RTEFI receive path
// Frame offsets count from the first byte after the SFD
// Status byte bit positions are shared by scanner and writer
package rtefi_pkg;

	// Start of frame delimiter that ends the preamble
	localparam logic [7:0] sfd_byte = 8'hd5;

	// Header field offsets, IPv4 with a 20-byte header assumed
	localparam int off_dst_mac = 0;
	localparam int off_ethertype = 12;
	localparam int off_ip_vers = 14;
	localparam int off_ip_proto = 23;
	localparam int off_dst_ip = 30;
	localparam int off_udp_dport = 36;

	// Address field lengths in bytes
	localparam int mac_len = 6;
	localparam int ip_len = 4;

	// Layout of the MAC/IP address memory
	localparam int cfg_mac_base = 0;
	localparam int cfg_ip_base = 6;

	// Status byte fields
	localparam int st_accept = 7;
	localparam int st_error = 6;
	localparam int st_mac_ok = 5;
	localparam int st_udp_ok = 4;
	localparam int st_ip_ok = 3;
	localparam int st_index = 0;
	localparam int index_w = 3;

	// UDP port table size, matches index_w
	localparam int n_udp_ports = 8;

	// Shortest acceptable frame, headers only
	localparam logic [7:0] min_len = 8'd42;

endpackage

/* scan_out_if.sv */
`timescale 1ns/1ns
// Scanner to writer link
// Carries frame bytes after the SFD with framing strobes
// plus the per-frame status byte and length at the last byte
interface scan_out_if #(
	parameter paw = 11
);

	// Byte stream
	logic [7:0] data;
	logic strobe;
	logic last;

	// Frame summary, valid with last
	logic [paw-1:0] pack_len;
	logic [7:0] status;
	logic status_valid;

	modport scanner (
		output data, strobe, last, pack_len, status, status_valid
	);

	modport writer (
		input data, strobe, last, pack_len, status, status_valid
	);

endinterface

/* addr_config.sv */
`timescale 1ns/1ns
// MAC/IP address memory
// Sixteen bytes, MAC in bytes 0-5 and IP in bytes 6-9
// Written from the config port, read by the scanner one cycle late
module addr_config import rtefi_pkg::*; #(
	parameter [47:0] mac = 48'h12555500012d,
	parameter [31:0] ip = {8'd192, 8'd168, 8'd7, 8'd4}
) (
	input logic rx_clk,
	input logic reset,
	input logic [3:0] config_a,
	input logic [7:0] config_d,
	input logic config_s,
	input logic [3:0] cfg_a,
	output logic [7:0] cfg_d
);

	logic [7:0] mem [0:15];

	// Reset reloads the synthesis-time addresses
	always_ff @(posedge rx_clk) begin
		if (reset) begin
			for (int i = 0; i < 16; i++)
				mem[i] <= 8'h00;
			// MAC goes in most significant byte first
			for (int i = 0; i < mac_len; i++)
				mem[cfg_mac_base + i] <= mac[47 - 8*i -: 8];
			for (int i = 0; i < ip_len; i++)
				mem[cfg_ip_base + i] <= ip[31 - 8*i -: 8];
		end else if (config_s) begin
			mem[config_a] <= config_d;
		end
	end

	// Registered read port for the scanner prefetch
	always_ff @(posedge rx_clk) begin
		cfg_d <= mem[cfg_a];
	end

endmodule

/* udp_port_cam.sv */
`timescale 1ns/1ns
// UDP destination port table
// Eight 16-bit entries compared in parallel against the scanned port
// Lowest matching entry wins, an entry of zero is disabled
module udp_port_cam import rtefi_pkg::*; #(
	parameter [15:0] udp_port0 = 7,
	parameter [15:0] udp_port1 = 801,
	parameter [15:0] udp_port2 = 802,
	parameter [15:0] udp_port3 = 803,
	parameter [15:0] udp_port4 = 0,
	parameter [15:0] udp_port5 = 0,
	parameter [15:0] udp_port6 = 0,
	parameter [15:0] udp_port7 = 0
) (
	input logic rx_clk,
	input logic reset,
	input logic [3:0] config_a,
	input logic [7:0] config_d,
	input logic config_p,
	input logic [15:0] dport,
	input logic dport_valid,
	output logic hit,
	output logic [index_w-1:0] index
);

	logic [15:0] port_tab [0:n_udp_ports-1];

	// Config bytes, even address is the high byte of entry config_a/2
	always_ff @(posedge rx_clk) begin
		if (reset) begin
			port_tab[0] <= udp_port0;
			port_tab[1] <= udp_port1;
			port_tab[2] <= udp_port2;
			port_tab[3] <= udp_port3;
			port_tab[4] <= udp_port4;
			port_tab[5] <= udp_port5;
			port_tab[6] <= udp_port6;
			port_tab[7] <= udp_port7;
		end else if (config_p) begin
			if (config_a[0])
				port_tab[config_a[3:1]][7:0] <= config_d;
			else
				port_tab[config_a[3:1]][15:8] <= config_d;
		end
	end

	// Scan from the top so the lowest index is left standing
	always_comb begin
		hit = 1'b0;
		index = '0;
		for (int i = n_udp_ports - 1; i >= 0; i--) begin
			if (dport_valid && port_tab[i] != 16'd0 && port_tab[i] == dport) begin
				hit = 1'b1;
				index = index_w'(i);
			end
		end
	end

	// Scanner asks once per frame, at the port low byte
	a_one_lookup: assert property (@(posedge rx_clk) disable iff (reset)
		dport_valid |=> !dport_valid);

endmodule

/* scanner.sv */
`timescale 1ns/1ns
// Rx header scanner
// Hunts the SFD, counts frame bytes and checks destination MAC,
// IPv4/UDP type, destination IP and UDP port against the config
// Bytes leave one cycle late so the final one can carry last
module scanner import rtefi_pkg::*; #(
	parameter paw = 11
) (
	input logic rx_clk,
	input logic reset,
	input logic [7:0] eth_in,
	input logic eth_in_s,
	input logic eth_in_e,
	input logic enable_rx,
	output logic [3:0] cfg_a,
	input logic [7:0] cfg_d,
	output logic [15:0] dport,
	output logic dport_valid,
	input logic hit,
	input logic [index_w-1:0] index,
	scan_out_if.scanner so,
	output logic [3:0] debug
);

	// FSM states
	localparam logic [1:0] s_hunt = 2'd0;
	localparam logic [1:0] s_frame = 2'd1;
	localparam logic [1:0] s_drop = 2'd2;

	// Expected header values
	localparam logic [7:0] ethertype_hi = 8'h08;
	localparam logic [7:0] ethertype_lo = 8'h00;
	localparam logic [7:0] ip_vers_ihl = 8'h45;
	localparam logic [7:0] proto_udp = 8'h11;

	logic [1:0] state;
	logic frame_byte;
	logic [paw-1:0] cnt, nxt_off, mac_rel, ip_rel;
	logic nxt_mac, nxt_ip, cmp_mac, cmp_ip;
	logic mac_ok, udp_ok, ip_ok, err, port_hit;
	logic [index_w-1:0] port_idx;
	logic [7:0] dport_hi;
	logic [7:0] hold_d;
	logic hold_v;
	logic frame_end;
	logic long_enough;
	logic [7:0] status_nx;

	assign frame_byte = (state == s_frame) && eth_in_s;

	// Frame state, enable_rx sampled at the SFD only
	always_ff @(posedge rx_clk) begin
		if (reset) begin
			state <= s_hunt;
		end else begin
			case (state)
				s_hunt:
					if (eth_in_s && eth_in == sfd_byte)
						state <= enable_rx ? s_frame : s_drop;
				s_frame, s_drop:
					if (!eth_in_s)
						state <= s_hunt;
				default:
					state <= s_hunt;
			endcase
		end
	end

	// Prefetch address for the byte after the current one
	always_comb begin
		nxt_off = (state == s_frame) ? cnt + 1'b1 : '0;
		mac_rel = nxt_off - paw'(off_dst_mac);
		ip_rel = nxt_off - paw'(off_dst_ip);
		nxt_mac = mac_rel < paw'(mac_len);
		nxt_ip = ip_rel < paw'(ip_len);
		if (nxt_ip)
			cfg_a = 4'(cfg_ip_base) + ip_rel[3:0];
		else
			cfg_a = 4'(cfg_mac_base) + mac_rel[3:0];
	end

	// Compare selects line up with cfg_d
	always_ff @(posedge rx_clk) begin
		cmp_mac <= nxt_mac;
		cmp_ip <= nxt_ip;
	end

	// Port number goes to the table at its low byte
	assign dport = {dport_hi, eth_in};
	assign dport_valid = frame_byte && cnt == paw'(off_udp_dport + 1);

	// Byte count and header flags, rearmed while hunting
	always_ff @(posedge rx_clk) begin
		if (state == s_hunt) begin
			cnt <= '0;
			mac_ok <= 1'b1;
			udp_ok <= 1'b1;
			ip_ok <= 1'b1;
			err <= 1'b0;
			port_hit <= 1'b0;
			port_idx <= '0;
		end else if (frame_byte) begin
			// Saturate so oversize frames stay visible downstream
			if (cnt != '1)
				cnt <= cnt + 1'b1;
			if (cmp_mac && eth_in != cfg_d)
				mac_ok <= 1'b0;
			if (cmp_ip && eth_in != cfg_d)
				ip_ok <= 1'b0;
			if (cnt == paw'(off_ethertype) && eth_in != ethertype_hi)
				udp_ok <= 1'b0;
			if (cnt == paw'(off_ethertype + 1) && eth_in != ethertype_lo)
				udp_ok <= 1'b0;
			if (cnt == paw'(off_ip_vers) && eth_in != ip_vers_ihl)
				udp_ok <= 1'b0;
			if (cnt == paw'(off_ip_proto) && eth_in != proto_udp)
				udp_ok <= 1'b0;
			if (cnt == paw'(off_udp_dport))
				dport_hi <= eth_in;
			if (dport_valid) begin
				port_hit <= hit;
				port_idx <= index;
			end
			if (eth_in_e)
				err <= 1'b1;
		end
	end

	// One byte of holdback to spot the end of frame
	always_ff @(posedge rx_clk) begin
		hold_d <= eth_in;
	end

	always_ff @(posedge rx_clk) begin
		if (reset)
			hold_v <= 1'b0;
		else
			hold_v <= frame_byte;
	end

	assign frame_end = hold_v && !frame_byte;
	assign long_enough = cnt >= paw'(min_len);

	// Status byte for the frame now ending
	always_comb begin
		status_nx = 8'h00;
		status_nx[st_accept] = mac_ok && udp_ok && ip_ok && port_hit && !err && long_enough;
		status_nx[st_error] = err;
		status_nx[st_mac_ok] = mac_ok;
		status_nx[st_udp_ok] = udp_ok;
		status_nx[st_ip_ok] = ip_ok;
		status_nx[st_index +: index_w] = port_idx;
	end

	// Output stage
	always_ff @(posedge rx_clk) begin
		so.data <= hold_d;
		so.pack_len <= cnt;
		so.status <= status_nx;
	end

	always_ff @(posedge rx_clk) begin
		if (reset) begin
			so.strobe <= 1'b0;
			so.last <= 1'b0;
			so.status_valid <= 1'b0;
		end else begin
			so.strobe <= hold_v;
			so.last <= frame_end;
			so.status_valid <= frame_end;
		end
	end

	assign debug = {state, mac_ok & ip_ok, udp_ok};

	// Frames refused at the SFD never reach the writer
	a_drop_silent: assert property (@(posedge rx_clk) disable iff (reset)
		state == s_drop |-> !so.strobe);

endmodule

/* pbuf_writer.sv */
`timescale 1ns/1ns
// Rx MAC memory writer
// Stores each scanned frame into the bank opposite the host bank
// Drops frames when that bank is still full and tracks bank status
module pbuf_writer import rtefi_pkg::*; #(
	parameter paw = 11
) (
	input logic rx_clk,
	input logic reset,
	scan_out_if.writer so,
	input logic rx_mac_hbank,
	output logic [7:0] rx_mac_d,
	output logic [paw:0] rx_mac_a,
	output logic rx_mac_wen,
	output logic [1:0] rx_mac_buf_status,
	output logic [7:0] rx_mac_status_d,
	output logic rx_mac_status_s
);

	logic in_frame, first;
	logic bank, drop;
	logic tgt_bank, tgt_drop;
	logic full, full_bank;
	logic fits, keep;
	logic [paw-1:0] off, tgt_off;
	logic [7:0] status_out;

	// Bank and drop decided at the first byte, held for the rest
	always_comb begin
		first = so.strobe && !in_frame;
		tgt_bank = first ? !rx_mac_hbank : bank;
		tgt_drop = first ? (full && full_bank == !rx_mac_hbank) : drop;
		tgt_off = first ? '0 : off;
		// Saturated length means the frame overran a bank
		fits = so.pack_len != '1;
		keep = so.status[st_accept] && fits && !tgt_drop;
		status_out = so.status;
		status_out[st_accept] = keep;
	end

	always_ff @(posedge rx_clk) begin
		if (reset) begin
			in_frame <= 1'b0;
			full <= 1'b0;
			full_bank <= 1'b0;
			rx_mac_wen <= 1'b0;
			rx_mac_status_s <= 1'b0;
		end else begin
			if (so.strobe)
				in_frame <= !so.last;
			rx_mac_wen <= so.strobe && !tgt_drop;
			rx_mac_status_s <= so.status_valid;
			// Host takes the full bank
			if (full && rx_mac_hbank == full_bank)
				full <= 1'b0;
			// Accepted frame locks its bank
			if (so.status_valid && keep) begin
				full <= 1'b1;
				full_bank <= tgt_bank;
			end
		end
	end

	always_ff @(posedge rx_clk) begin
		if (so.strobe) begin
			bank <= tgt_bank;
			drop <= tgt_drop;
			off <= tgt_off + 1'b1;
		end
		rx_mac_d <= so.data;
		rx_mac_a <= {tgt_bank, tgt_off};
		rx_mac_status_d <= status_out;
	end

	assign rx_mac_buf_status = {full, full_bank};

	// Host reads its bank while we fill the other
	a_bank_owned: assert property (@(posedge rx_clk) disable iff (reset)
		rx_mac_wen |-> rx_mac_a[paw] != rx_mac_hbank);

endmodule

/* rtefi_center.sv */
`timescale 1ns/1ns
// RTEFI receive center
// Abstract GMII in, scanned frames out to a two-bank Rx MAC memory
// Chain is a_scan then b_write with address and port tables alongside
module rtefi_center #(
	// Offset width within one Rx MAC bank
	parameter paw = 11,
	// Defaults below can be rewritten through the config port
	parameter [47:0] mac = 48'h12555500012d,
	parameter [31:0] ip = {8'd192, 8'd168, 8'd7, 8'd4},
	parameter [15:0] udp_port0 = 7,
	parameter [15:0] udp_port1 = 801,
	parameter [15:0] udp_port2 = 802,
	parameter [15:0] udp_port3 = 803,
	parameter [15:0] udp_port4 = 0,
	parameter [15:0] udp_port5 = 0,
	parameter [15:0] udp_port6 = 0,
	parameter [15:0] udp_port7 = 0
) (
	input logic rx_clk,
	input logic reset,
	// GMII receive
	input logic [7:0] rxd,
	input logic rx_dv,
	input logic rx_er,
	// Configuration
	input logic enable_rx,
	input logic [3:0] config_a,
	input logic [7:0] config_d,
	input logic config_s,
	input logic config_p,
	// Rx MAC memory and handshake
	output logic [7:0] rx_mac_d,
	output logic [paw:0] rx_mac_a,
	output logic rx_mac_wen,
	input logic rx_mac_hbank,
	output logic [1:0] rx_mac_buf_status,
	output logic [7:0] rx_mac_status_d,
	output logic rx_mac_status_s,
	// Activity monitors
	output logic rx_mon,
	output logic [3:0] scanner_debug
);

	logic [7:0] eth_in_r;
	logic eth_in_s_r, eth_in_e_r;
	logic [3:0] cfg_a;
	logic [7:0] cfg_d;
	logic [15:0] dport;
	logic dport_valid;
	logic port_hit;
	logic [2:0] port_index;

	// GMII input registers, kept close to the pins
	always_ff @(posedge rx_clk) begin
		eth_in_r <= rxd;
	end

	always_ff @(posedge rx_clk) begin
		if (reset) begin
			eth_in_s_r <= 1'b0;
			eth_in_e_r <= 1'b0;
		end else begin
			eth_in_s_r <= rx_dv;
			eth_in_e_r <= rx_er;
		end
	end

	scan_out_if #(.paw(paw)) scan_if ();

	addr_config #(.mac(mac), .ip(ip)) u_addr_config (
		.rx_clk(rx_clk), .reset(reset),
		.config_a(config_a), .config_d(config_d), .config_s(config_s),
		.cfg_a(cfg_a), .cfg_d(cfg_d)
	);

	udp_port_cam #(
		.udp_port0(udp_port0), .udp_port1(udp_port1),
		.udp_port2(udp_port2), .udp_port3(udp_port3),
		.udp_port4(udp_port4), .udp_port5(udp_port5),
		.udp_port6(udp_port6), .udp_port7(udp_port7)
	) u_udp_port_cam (
		.rx_clk(rx_clk), .reset(reset),
		.config_a(config_a), .config_d(config_d), .config_p(config_p),
		.dport(dport), .dport_valid(dport_valid),
		.hit(port_hit), .index(port_index)
	);

	// First step scans the incoming frame
	scanner #(.paw(paw)) a_scan (
		.rx_clk(rx_clk), .reset(reset),
		.eth_in(eth_in_r), .eth_in_s(eth_in_s_r), .eth_in_e(eth_in_e_r),
		.enable_rx(enable_rx),
		.cfg_a(cfg_a), .cfg_d(cfg_d),
		.dport(dport), .dport_valid(dport_valid),
		.hit(port_hit), .index(port_index),
		.so(scan_if.scanner), .debug(scanner_debug)
	);

	// Second step stores it for the host
	pbuf_writer #(.paw(paw)) b_write (
		.rx_clk(rx_clk), .reset(reset),
		.so(scan_if.writer), .rx_mac_hbank(rx_mac_hbank),
		.rx_mac_d(rx_mac_d), .rx_mac_a(rx_mac_a), .rx_mac_wen(rx_mac_wen),
		.rx_mac_buf_status(rx_mac_buf_status),
		.rx_mac_status_d(rx_mac_status_d), .rx_mac_status_s(rx_mac_status_s)
	);

	assign rx_mon = eth_in_s_r;

endmodule

/* tb_rtefi_center.sv */
`timescale 1ns/1ns
// Testbench for the RTEFI receive center
// Sends directed GMII frames, predicts each status byte from the header rules
// and checks Rx MAC writes, status pulses and bank status
module tb_rtefi_center import rtefi_pkg::*; ();

	localparam int paw = 11;
	localparam logic [47:0] def_mac = 48'h12555500012d;
	localparam logic [31:0] def_ip = 32'hc0a80704;
	localparam int payload_len = 8;
	// Headers, payload and dummy FCS
	localparam int max_len = 42 + payload_len + 4;
	localparam int status_wait = 10;
	// Preamble, bytes, status wait, gap and bank release per frame
	localparam int frame_cycles = 8 + max_len + status_wait + 8;
	localparam int n_frames = 12;
	localparam int cycle_limit = n_frames * frame_cycles + 300;

	logic rx_clk, reset;
	logic [7:0] rxd;
	logic rx_dv, rx_er, enable_rx;
	logic [3:0] config_a;
	logic [7:0] config_d;
	logic config_s, config_p, rx_mac_hbank;
	logic [7:0] rx_mac_d;
	logic [paw:0] rx_mac_a;
	logic rx_mac_wen;
	logic [1:0] rx_mac_buf_status;
	logic [7:0] rx_mac_status_d;
	logic rx_mac_status_s, rx_mon;
	logic [3:0] scanner_debug;

	// Expected configuration and bank state
	logic [47:0] cur_mac;
	logic [31:0] cur_ip;
	logic [15:0] ports [0:7];
	logic tb_full, tb_full_bank;

	// Frame under test and monitor records
	logic [7:0] frame [0:max_len-1];
	int frame_len;
	logic [paw:0] wr_a [$];
	logic [7:0] wr_d [$];
	int n_status = 0;
	logic [7:0] last_status;
	int errors, tests, test_start;
	int cycles = 0;

	rtefi_center #(.paw(paw), .mac(def_mac), .ip(def_ip)) u_rtefi_center (
		.rx_clk(rx_clk), .reset(reset),
		.rxd(rxd), .rx_dv(rx_dv), .rx_er(rx_er),
		.enable_rx(enable_rx), .config_a(config_a), .config_d(config_d),
		.config_s(config_s), .config_p(config_p),
		.rx_mac_d(rx_mac_d), .rx_mac_a(rx_mac_a), .rx_mac_wen(rx_mac_wen),
		.rx_mac_hbank(rx_mac_hbank), .rx_mac_buf_status(rx_mac_buf_status),
		.rx_mac_status_d(rx_mac_status_d), .rx_mac_status_s(rx_mac_status_s),
		.rx_mon(rx_mon), .scanner_debug(scanner_debug)
	);

	initial begin
		rx_clk = 1'b0;
		forever #4 rx_clk = ~rx_clk;
	end

	// Run limit from the frame count
	always @(posedge rx_clk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Run stopped after %0d cycles without finishing", cycle_limit);
			$display("Testbench failed");
			$finish;
		end
	end

	// Outputs sampled mid-cycle
	always @(negedge rx_clk) begin
		if (!reset && rx_mac_wen) begin
			wr_a.push_back(rx_mac_a);
			wr_d.push_back(rx_mac_d);
		end
		if (!reset && rx_mac_status_s) begin
			n_status = n_status + 1;
			last_status = rx_mac_status_d;
		end
	end

	task automatic tick();
		@(posedge rx_clk);
		#1;
	endtask

	// Status byte from the header rules and the current config
	function automatic logic [7:0] predict_status(input logic [47:0] dmac,
		input logic [31:0] dip, input logic [15:0] dport, input logic err, input logic drop);
		logic [7:0] s;
		logic hit;
		logic [2:0] idx;
		hit = 1'b0;
		idx = 3'd0;
		for (int i = 0; i < n_udp_ports; i++) begin
			if (!hit && ports[i] != 16'd0 && ports[i] == dport) begin
				hit = 1'b1;
				idx = 3'(i);
			end
		end
		s = 8'h00;
		s[st_mac_ok] = dmac == cur_mac;
		s[st_udp_ok] = 1'b1;
		s[st_ip_ok] = dip == cur_ip;
		s[st_error] = err;
		s[st_index +: 3] = idx;
		s[st_accept] = s[st_mac_ok] && s[st_ip_ok] && hit && !err && !drop
			&& frame_len >= int'(min_len);
		return s;
	endfunction

	// Ethernet, IPv4 and UDP headers, random payload, dummy FCS
	task automatic build_frame(input logic [47:0] dmac, input logic [31:0] dip,
		input logic [15:0] dport);
		frame_len = max_len;
		for (int i = 0; i < 42; i++)
			frame[i] = 8'h00;
		for (int i = 0; i < 6; i++) begin
			frame[i] = dmac[47 - 8*i -: 8];
			frame[6 + i] = 8'(32 + i);
		end
		frame[12] = 8'h08;
		frame[14] = 8'h45;
		frame[17] = 8'(28 + payload_len);
		frame[22] = 8'h40;
		frame[23] = 8'h11;
		for (int i = 0; i < 4; i++) begin
			frame[26 + i] = def_ip[31 - 8*i -: 8] ^ 8'(i == 3 ? 5 : 0);
			frame[30 + i] = dip[31 - 8*i -: 8];
		end
		frame[34] = 8'h04;
		frame[35] = 8'hd2;
		frame[36] = dport[15:8];
		frame[37] = dport[7:0];
		frame[39] = 8'(8 + payload_len);
		for (int i = 42; i < max_len; i++)
			frame[i] = 8'($urandom);
	endtask

	// Preamble and SFD, then the frame with rx_er on one byte if asked
	task automatic send_frame(input int err_at);
		rx_dv = 1'b1;
		for (int i = 0; i < 7; i++) begin
			rxd = 8'h55;
			tick();
		end
		rxd = sfd_byte;
		tick();
		for (int i = 0; i < frame_len; i++) begin
			rxd = frame[i];
			rx_er = i == err_at;
			tick();
		end
		rx_dv = 1'b0;
		rx_er = 1'b0;
		rxd = 8'h00;
	endtask

	// Send one frame and check status, writes and bank status
	task automatic run_frame(input logic [47:0] dmac, input logic [31:0] dip,
		input logic [15:0] dport, input int err_at);
		logic drop, bank, got, on;
		logic [7:0] exp_st;
		logic [3:0] exp_dbg;
		int start_w, start_s, n_w;
		on = enable_rx;
		bank = !rx_mac_hbank;
		drop = tb_full && tb_full_bank == bank;
		build_frame(dmac, dip, dport);
		exp_st = predict_status(dmac, dip, dport, err_at >= 0, drop);
		// Scanner still in the frame state with its header flags settled
		exp_dbg = {2'b01, exp_st[st_mac_ok] & exp_st[st_ip_ok], exp_st[st_udp_ok]};
		start_w = wr_a.size();
		start_s = n_status;
		send_frame(err_at);
		// Last byte is still in the input register
		if (rx_mon !== 1'b1) begin
			$display("Fail rx_mon: got 0x%01h, expected 0x1", rx_mon);
			errors++;
		end
		if (on && scanner_debug !== exp_dbg) begin
			$display("Fail scanner_debug: got 0x%01h, expected 0x%01h",
				scanner_debug, exp_dbg);
			errors++;
		end
		got = 1'b0;
		for (int i = 0; i < status_wait && !got; i++) begin
			tick();
			got = n_status != start_s;
		end
		if (rx_mon !== 1'b0) begin
			$display("Fail rx_mon: got 0x%01h, expected 0x0", rx_mon);
			errors++;
		end
		n_w = wr_a.size() - start_w;
		if (!on) begin
			if (got || n_w != 0) begin
				$display("Frame sent with enable_rx low was not ignored");
				errors++;
			end
		end else begin
			if (!got) begin
				$display("No status pulse after the frame");
				errors++;
			end else if (last_status !== exp_st) begin
				$display("Fail rx_mac_status_d: got 0x%02h, expected 0x%02h",
					last_status, exp_st);
				errors++;
			end
			if (drop && n_w != 0) begin
				$display("Dropped frame still wrote %0d bytes", n_w);
				errors++;
			end else if (!drop && n_w != frame_len) begin
				$display("Frame wrote %0d bytes instead of %0d", n_w, frame_len);
				errors++;
			end else if (!drop) begin
				for (int i = 0; i < frame_len; i++) begin
					if (wr_a[start_w + i] !== {bank, paw'(i)}) begin
						$display("Fail rx_mac_a: got 0x%03h, expected 0x%03h",
							wr_a[start_w + i], {bank, paw'(i)});
						errors++;
					end
					if (wr_d[start_w + i] !== frame[i]) begin
						$display("Fail rx_mac_d: got 0x%02h, expected 0x%02h",
							wr_d[start_w + i], frame[i]);
						errors++;
					end
				end
			end
			// Accepted frame locks its bank
			if (exp_st[st_accept]) begin
				tb_full = 1'b1;
				tb_full_bank = bank;
			end
		end
		if (rx_mac_buf_status !== {tb_full, tb_full_bank}) begin
			$display("Fail rx_mac_buf_status: got 0x%01h, expected 0x%01h",
				rx_mac_buf_status, {tb_full, tb_full_bank});
			errors++;
		end
		repeat (4) tick();
	endtask

	task automatic set_hbank(input logic b);
		rx_mac_hbank = b;
		repeat (2) tick();
		if (tb_full && b == tb_full_bank)
			tb_full = 1'b0;
	endtask

	// Host takes the full bank so the other one is free
	task automatic release_bank();
		if (tb_full)
			set_hbank(tb_full_bank);
	endtask

	// High byte on the even address
	task automatic write_port(input int entry, input logic [15:0] value);
		config_p = 1'b1;
		config_a = 4'(2 * entry);
		config_d = value[15:8];
		tick();
		config_a = 4'(2 * entry + 1);
		config_d = value[7:0];
		tick();
		config_p = 1'b0;
		ports[entry] = value;
	endtask

	task automatic write_ip(input logic [31:0] value);
		for (int i = 0; i < 4; i++) begin
			config_s = 1'b1;
			config_a = 4'(cfg_ip_base + i);
			config_d = value[31 - 8*i -: 8];
			tick();
		end
		config_s = 1'b0;
		cur_ip = value;
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("Test %0d %s: %0d errors", tests, name, errors - test_start);
		test_start = errors;
	endtask

	task automatic test_good_frame();
		release_bank();
		run_frame(cur_mac, cur_ip, 16'd801, -1);
		finish_test("good frame to port 801");
	endtask

	// Free bank so a rejected frame is written and only its flags refuse it
	task automatic test_rejects();
		release_bank();
		run_frame(cur_mac ^ 48'h1, cur_ip, 16'd801, -1);
		run_frame(cur_mac, cur_ip, 16'd999, -1);
		enable_rx = 1'b0;
		run_frame(cur_mac, cur_ip, 16'd801, -1);
		enable_rx = 1'b1;
		finish_test("wrong MAC, unlisted port, receive disabled");
	endtask

	task automatic test_config();
		logic [31:0] old_ip;
		old_ip = cur_ip;
		write_port(2, 16'd900);
		release_bank();
		run_frame(cur_mac, cur_ip, 16'd900, -1);
		release_bank();
		run_frame(cur_mac, cur_ip, 16'd802, -1);
		write_ip(32'h0a000009);
		release_bank();
		run_frame(cur_mac, cur_ip, 16'd801, -1);
		release_bank();
		run_frame(cur_mac, old_ip, 16'd801, -1);
		finish_test("port and IP rewrite");
	endtask

	task automatic test_rx_error();
		release_bank();
		run_frame(cur_mac, cur_ip, 16'd801, 45);
		finish_test("rx_er in payload");
	endtask

	// Second frame hits the full bank, third goes to the other one
	task automatic test_bank_full();
		release_bank();
		run_frame(cur_mac, cur_ip, 16'd801, -1);
		run_frame(cur_mac, cur_ip, 16'd803, -1);
		set_hbank(!rx_mac_hbank);
		run_frame(cur_mac, cur_ip, 16'd7, -1);
		finish_test("full bank drop and host flip");
	endtask

	initial begin
		void'($urandom(38898));
		reset = 1'b1;
		rxd = 8'h00;
		rx_dv = 1'b0;
		rx_er = 1'b0;
		enable_rx = 1'b1;
		config_a = 4'h0;
		config_d = 8'h00;
		config_s = 1'b0;
		config_p = 1'b0;
		rx_mac_hbank = 1'b0;
		cur_mac = def_mac;
		cur_ip = def_ip;
		ports = '{16'd7, 16'd801, 16'd802, 16'd803, 16'd0, 16'd0, 16'd0, 16'd0};
		tb_full = 1'b0;
		tb_full_bank = 1'b0;
		errors = 0;
		tests = 0;
		test_start = 0;
		repeat (10) @(posedge rx_clk);
		#1;
		reset = 1'b0;
		repeat (3) tick();
		test_good_frame();
		test_rejects();
		test_config();
		test_rx_error();
		test_bank_full();
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* files.f */
rtefi_pkg.sv
scan_out_if.sv
addr_config.sv
udp_port_cam.sv
scanner.sv
pbuf_writer.sv
rtefi_center.sv
tb_rtefi_center.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_rtefi_center
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
